//--- source/z80_block_pkg.sv
/* Shared types and encodings for the block compare subsystem.
   Flag bits 3 and 5 are not modelled and pass through untouched. */

package z80_block_pkg;

    // ####################
    // data widths
    // ####################

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [4:0]  xpt_t;
    typedef logic [7:0]  flags_t;

    // ####################
    // F register bit positions
    // ####################

    localparam int FLAG_S  = 7;
    localparam int FLAG_Z  = 6;
    localparam int FLAG_H  = 4;
    localparam int FLAG_PV = 2;
    localparam int FLAG_N  = 1;
    localparam int FLAG_C  = 0;

    // ####################
    // state machines
    // ####################

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_STEP,
        EX_WAIT
    } exec_state_e;

    // fe_hold drains a read that was still in flight when the instruction ended.
    typedef enum logic [1:0] {
        FE_IDLE,
        FE_REQ,
        FE_WAIT,
        FE_HOLD
    } fetch_state_e;

endpackage

//--- source/block_fetch_unit.sv
/* One read outstanding at a time; a count of 0 means 65536 bytes.
   A request is withdrawn if flush arrives before it is accepted. */
`timescale 1ns/1ps

module block_fetch_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  z80_block_pkg::word_t start_addr,
    input  z80_block_pkg::word_t start_count,
    input  logic                 dir,
    input  logic                 flush,
    input  logic                 fifo_space,
    input  logic                 mem_ready,
    input  logic                 mem_rvalid,
    input  z80_block_pkg::byte_t mem_rdata,
    output logic                 mem_valid,
    output z80_block_pkg::word_t mem_addr,
    output logic                 push,
    output z80_block_pkg::byte_t push_data
);

    z80_block_pkg::fetch_state_e state;
    z80_block_pkg::word_t        addr;
    logic [16:0]                 remaining;
    logic                        accept;

    // space only shrinks on a push, so a raised request stays raised until accepted.
    assign mem_valid = (state == z80_block_pkg::FE_REQ) && fifo_space;
    assign mem_addr  = addr;
    assign accept    = mem_valid && mem_ready;
    assign push      = (state == z80_block_pkg::FE_WAIT) && mem_rvalid && !flush;
    assign push_data = mem_rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= z80_block_pkg::FE_IDLE;
            remaining <= '0;
        end else begin
            if (start) begin
                remaining <= (start_count == '0) ? 17'h1_0000 : {1'b0, start_count};
            end else if (flush) begin
                remaining <= '0;
            end else if (accept) begin
                remaining <= remaining - 17'd1;
            end

            case (state)
                z80_block_pkg::FE_IDLE: begin
                    if (start) begin
                        state <= z80_block_pkg::FE_REQ;
                    end
                end
                z80_block_pkg::FE_REQ: begin
                    if (flush) begin
                        state <= accept ? z80_block_pkg::FE_HOLD : z80_block_pkg::FE_IDLE;
                    end else if (accept) begin
                        state <= z80_block_pkg::FE_WAIT;
                    end
                end
                z80_block_pkg::FE_WAIT: begin
                    if (mem_rvalid) begin
                        state <= (remaining != '0 && !flush) ? z80_block_pkg::FE_REQ
                                                             : z80_block_pkg::FE_IDLE;
                    end else if (flush) begin
                        state <= z80_block_pkg::FE_HOLD;
                    end
                end
                default: begin
                    // the next instruction may already have started while we drain.
                    if (mem_rvalid) begin
                        state <= (start || remaining != '0) ? z80_block_pkg::FE_REQ
                                                            : z80_block_pkg::FE_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr <= start_addr;
        end else if (accept) begin
            addr <= dir ? addr - 16'd1 : addr + 16'd1;
        end
    end

endmodule

//--- source/operand_fifo.sv
/* FIFO_DEPTH must be a power of two, 2 or more.
   One slot stays reserved for the read that is in flight. */
`timescale 1ns/1ps

module operand_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 push,
    input  z80_block_pkg::byte_t push_data,
    input  logic                 pop,
    output z80_block_pkg::byte_t pop_data,
    output logic                 empty,
    output logic                 fifo_space
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] SPACE_LIMIT = (PTR_W + 1)'(FIFO_DEPTH - 1);

    z80_block_pkg::byte_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W:0]       count;
    logic                 do_push;
    logic                 do_pop;

    assign do_push    = push && !flush;
    assign do_pop     = pop && !flush && (count != '0);
    assign pop_data   = mem[rd_ptr];
    assign empty      = (count == '0);
    assign fifo_space = count < SPACE_LIMIT;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

//--- source/cp_step_decoder.sv
/* Pure decode of timing states 4 to 9 for CPI, CPD, CPIR and CPDR.
   Any other state number gives no strobe. */
`timescale 1ns/1ps

module cp_step_decoder (
    input  logic                enable,
    input  z80_block_pkg::xpt_t xpt,
    input  logic                dir,
    output logic                step_read,
    output logic                latch_operand,
    output logic                write_szh,
    output logic                write_bc_pv,
    output logic                write_hl_n,
    output logic                hl_sub,
    output logic                hl_add,
    output logic                last_step
);

    always_comb begin
        step_read     = 1'b0;
        latch_operand = 1'b0;
        write_szh     = 1'b0;
        write_bc_pv   = 1'b0;
        write_hl_n    = 1'b0;
        hl_sub        = 1'b0;
        hl_add        = 1'b0;
        last_step     = 1'b0;
        if (enable) begin
            case (xpt)
                // 4 and 5 only hold the read phase open.
                5'd4, 5'd5: begin
                    step_read = 1'b1;
                end
                5'd6: begin
                    step_read     = 1'b1;
                    latch_operand = 1'b1;
                end
                5'd7: begin
                    write_szh = 1'b1;
                end
                5'd8: begin
                    write_bc_pv = 1'b1;
                end
                5'd9: begin
                    write_hl_n = 1'b1;
                    hl_sub     = dir;
                    hl_add     = !dir;
                    last_step  = 1'b1;
                end
                default: begin
                    step_read = 1'b0;
                end
            endcase
        end
    end

endmodule

//--- source/compare_execute_unit.sv
/* Carry and flag bits 3 and 5 keep their command values.
   Repeat forms take no extra timing states. */
`timescale 1ns/1ps

module compare_execute_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    input  logic                  cmd_dir,
    input  logic                  cmd_repeat,
    input  z80_block_pkg::byte_t  cmd_a,
    input  z80_block_pkg::word_t  cmd_bc,
    input  z80_block_pkg::word_t  cmd_hl,
    input  z80_block_pkg::flags_t cmd_f,
    input  z80_block_pkg::byte_t  pop_data,
    input  logic                  empty,
    output logic                  cmd_ready,
    output logic                  start,
    output z80_block_pkg::word_t  start_addr,
    output z80_block_pkg::word_t  start_count,
    output logic                  dir,
    output logic                  pop,
    output logic                  flush,
    output logic                  done,
    output z80_block_pkg::word_t  res_bc,
    output z80_block_pkg::word_t  res_hl,
    output z80_block_pkg::flags_t res_f
);

    z80_block_pkg::exec_state_e state;
    z80_block_pkg::xpt_t        xpt;
    z80_block_pkg::byte_t       a_reg;
    z80_block_pkg::byte_t       operand;
    z80_block_pkg::word_t       bc_reg;
    z80_block_pkg::word_t       hl_reg;
    z80_block_pkg::flags_t      f_reg;
    z80_block_pkg::word_t       bc_next;
    logic                       repeat_reg;
    logic                       accept;
    logic                       finish;
    logic [8:0]                 diff;
    logic [4:0]                 half_diff;
    logic                       step_read;
    logic                       latch_operand;
    logic                       write_szh;
    logic                       write_bc_pv;
    logic                       write_hl_n;
    logic                       hl_sub;
    logic                       hl_add;
    logic                       last_step;

    cp_step_decoder cp_step_decoder_inst (
        .enable        (state != z80_block_pkg::EX_IDLE),
        .xpt           (xpt),
        .dir           (dir),
        .step_read     (step_read),
        .latch_operand (latch_operand),
        .write_szh     (write_szh),
        .write_bc_pv   (write_bc_pv),
        .write_hl_n    (write_hl_n),
        .hl_sub        (hl_sub),
        .hl_add        (hl_add),
        .last_step     (last_step)
    );

    assign cmd_ready   = (state == z80_block_pkg::EX_IDLE);
    assign accept      = cmd_valid && cmd_ready;
    assign start_addr  = hl_reg;
    assign start_count = bc_reg;
    assign pop         = latch_operand && step_read && !empty;
    assign flush       = done;
    assign res_bc      = bc_reg;
    assign res_hl      = hl_reg;
    assign res_f       = f_reg;

    // the borrow out of bit 3 is the Z80 H flag for a subtract.
    assign diff      = {1'b0, a_reg} - {1'b0, operand};
    assign half_diff = {1'b0, a_reg[3:0]} - {1'b0, operand[3:0]};
    assign bc_next   = bc_reg - 16'd1;
    assign finish    = !repeat_reg || (bc_reg == '0) || f_reg[z80_block_pkg::FLAG_Z];

    // ####################
    // sequencing
    // ####################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= z80_block_pkg::EX_IDLE;
            xpt   <= 5'd4;
            start <= 1'b0;
            done  <= 1'b0;
        end else begin
            start <= 1'b0;
            done  <= 1'b0;
            if (state == z80_block_pkg::EX_IDLE) begin
                if (accept) begin
                    state <= z80_block_pkg::EX_STEP;
                    xpt   <= 5'd4;
                    start <= 1'b1;
                end
            end else if (latch_operand && empty) begin
                state <= z80_block_pkg::EX_WAIT;
            end else if (last_step) begin
                if (finish) begin
                    state <= z80_block_pkg::EX_IDLE;
                    done  <= 1'b1;
                end else begin
                    xpt <= 5'd4;
                end
            end else begin
                state <= z80_block_pkg::EX_STEP;
                xpt   <= xpt + 5'd1;
            end
        end
    end

    // ####################
    // registers and flags
    // ####################

    always_ff @(posedge clk) begin
        if (accept) begin
            a_reg      <= cmd_a;
            bc_reg     <= cmd_bc;
            hl_reg     <= cmd_hl;
            f_reg      <= cmd_f;
            dir        <= cmd_dir;
            repeat_reg <= cmd_repeat;
        end else begin
            if (pop) begin
                operand <= pop_data;
            end
            if (write_szh) begin
                f_reg[z80_block_pkg::FLAG_S] <= diff[7];
                f_reg[z80_block_pkg::FLAG_Z] <= (diff[7:0] == 8'h00);
                f_reg[z80_block_pkg::FLAG_H] <= half_diff[4];
            end
            if (write_bc_pv) begin
                bc_reg                        <= bc_next;
                f_reg[z80_block_pkg::FLAG_PV] <= (bc_next != '0);
            end
            if (write_hl_n) begin
                f_reg[z80_block_pkg::FLAG_N] <= 1'b1;
                if (hl_sub) begin
                    hl_reg <= hl_reg - 16'd1;
                end else if (hl_add) begin
                    hl_reg <= hl_reg + 16'd1;
                end
            end
        end
    end

endmodule

//--- source/block_compare_top.sv
/* Memory returns must arrive in order, one per accepted read.
   FIFO_DEPTH is a power of two, 2 or more. */
`timescale 1ns/1ps

module block_compare_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    input  logic                  cmd_dir,
    input  logic                  cmd_repeat,
    input  z80_block_pkg::byte_t  cmd_a,
    input  z80_block_pkg::word_t  cmd_bc,
    input  z80_block_pkg::word_t  cmd_hl,
    input  z80_block_pkg::flags_t cmd_f,
    output logic                  cmd_ready,
    output logic                  mem_valid,
    output z80_block_pkg::word_t  mem_addr,
    input  logic                  mem_ready,
    input  logic                  mem_rvalid,
    input  z80_block_pkg::byte_t  mem_rdata,
    output logic                  done,
    output z80_block_pkg::word_t  res_bc,
    output z80_block_pkg::word_t  res_hl,
    output z80_block_pkg::flags_t res_f
);

    logic                 start;
    logic                 dir;
    logic                 flush;
    logic                 push;
    logic                 pop;
    logic                 empty;
    logic                 fifo_space;
    z80_block_pkg::word_t start_addr;
    z80_block_pkg::word_t start_count;
    z80_block_pkg::byte_t push_data;
    z80_block_pkg::byte_t pop_data;

    block_fetch_unit block_fetch_unit_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .start_addr  (start_addr),
        .start_count (start_count),
        .dir         (dir),
        .flush       (flush),
        .fifo_space  (fifo_space),
        .mem_ready   (mem_ready),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .mem_valid   (mem_valid),
        .mem_addr    (mem_addr),
        .push        (push),
        .push_data   (push_data)
    );

    operand_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) operand_fifo_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .push       (push),
        .push_data  (push_data),
        .pop        (pop),
        .pop_data   (pop_data),
        .empty      (empty),
        .fifo_space (fifo_space)
    );

    compare_execute_unit compare_execute_unit_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_dir     (cmd_dir),
        .cmd_repeat  (cmd_repeat),
        .cmd_a       (cmd_a),
        .cmd_bc      (cmd_bc),
        .cmd_hl      (cmd_hl),
        .cmd_f       (cmd_f),
        .pop_data    (pop_data),
        .empty       (empty),
        .cmd_ready   (cmd_ready),
        .start       (start),
        .start_addr  (start_addr),
        .start_count (start_count),
        .dir         (dir),
        .pop         (pop),
        .flush       (flush),
        .done        (done),
        .res_bc      (res_bc),
        .res_hl      (res_hl),
        .res_f       (res_f)
    );

endmodule

//--- testbench/tb_clock_gen.sv
/* Free-running clock with no enable; the period is a whole number of ns. */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

//--- testbench/block_compare_assertions.sv
/* Protocol checks bound into block_compare_top; the failure count is read at the end. */
`timescale 1ns/1ps

module block_compare_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 cmd_ready,
    input logic                 start,
    input logic                 done,
    input logic                 mem_valid,
    input logic                 mem_ready,
    input z80_block_pkg::word_t mem_addr
);

    int unsigned failures = 0;

    // a stalled read keeps its address until memory takes it.
    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_valid && !mem_ready && !done) |=> (mem_valid && $stable(mem_addr)))
    else begin
        $error("mem_addr moved while a read was stalled");
        failures++;
    end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else begin
        $error("done stayed high for more than one cycle");
        failures++;
    end

    // the command port only reopens together with done.
    busy_start: assert property (@(posedge clk) disable iff (!rst_n)
        (start |-> !cmd_ready) and ($rose(cmd_ready) |-> done))
    else begin
        $error("cmd_ready was high while an instruction was running");
        failures++;
    end

    reset_quiet: assert property (@(posedge clk) !rst_n |=> (!mem_valid && !done && cmd_ready))
    else begin
        $error("outputs not at their idle values after reset");
        failures++;
    end

endmodule

//--- testbench/tb_block_compare.sv
/* Runs the cases from testbench/block_compare_cases.txt, relative to the project root.
   The memory model holds one read at a time and answers 1 to 3 cycles later. */
`timescale 1ns/1ps

module tb_block_compare;

    localparam int NUM_CASES  = 9;
    localparam int CASE_WORDS = 9;
    localparam int WAIT_LIMIT = 1000;

    logic                  clk;
    logic                  rst_n;
    logic                  cmd_valid;
    logic                  cmd_dir;
    logic                  cmd_repeat;
    z80_block_pkg::byte_t  cmd_a;
    z80_block_pkg::word_t  cmd_bc;
    z80_block_pkg::word_t  cmd_hl;
    z80_block_pkg::flags_t cmd_f;
    logic                  cmd_ready;
    logic                  mem_valid;
    z80_block_pkg::word_t  mem_addr;
    logic                  mem_ready = 1'b0;
    logic                  mem_rvalid = 1'b0;
    z80_block_pkg::byte_t  mem_rdata = '0;
    logic                  done;
    z80_block_pkg::word_t  res_bc;
    z80_block_pkg::word_t  res_hl;
    z80_block_pkg::flags_t res_f;

    logic [15:0]           case_mem [NUM_CASES * CASE_WORDS];
    logic [31:0]           lfsr_state = 32'hfd05_c689;
    logic                  seen_accept = 1'b0;
    z80_block_pkg::word_t  seen_addr = '0;
    logic                  pending = 1'b0;
    z80_block_pkg::word_t  pend_addr = '0;
    logic [1:0]            delay_left = '0;
    int                    value_errors = 0;
    int                    timeouts = 0;
    int                    protocol_errors = 0;
    int                    assert_failures = 0;

    tb_clock_gen #(.PERIOD_NS(4)) tb_clock_gen_inst (.clk(clk));

    block_compare_top #(
        .FIFO_DEPTH (4)
    ) block_compare_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_dir    (cmd_dir),
        .cmd_repeat (cmd_repeat),
        .cmd_a      (cmd_a),
        .cmd_bc     (cmd_bc),
        .cmd_hl     (cmd_hl),
        .cmd_f      (cmd_f),
        .cmd_ready  (cmd_ready),
        .mem_valid  (mem_valid),
        .mem_addr   (mem_addr),
        .mem_ready  (mem_ready),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .done       (done),
        .res_bc     (res_bc),
        .res_hl     (res_hl),
        .res_f      (res_f)
    );

    bind block_compare_top block_compare_assertions block_compare_assertions_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_ready (cmd_ready),
        .start     (start),
        .done      (done),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_addr  (mem_addr)
    );

    // taps 32, 22, 2 and 1 give a maximal-length sequence.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < count; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // ####################
    // memory model
    // ####################

    always @(negedge clk) begin
        seen_accept = mem_valid && mem_ready;
        seen_addr   = mem_addr;
    end

    always @(posedge clk) begin
        logic [31:0] bits;
        if (!rst_n) begin
            mem_ready  <= 1'b0;
            mem_rvalid <= 1'b0;
            pending    = 1'b0;
        end else begin
            mem_rvalid <= 1'b0;
            if (seen_accept) begin
                if (pending) begin
                    protocol_errors++;
                    $display("Memory model got a second read while one was outstanding");
                end
                take_bits(2, bits);
                pending    = 1'b1;
                pend_addr  = seen_addr;
                delay_left = (bits[1:0] == 2'd3) ? 2'd0 : bits[1:0];
            end
            if (pending) begin
                if (delay_left == 2'd0) begin
                    mem_rvalid <= 1'b1;
                    mem_rdata  <= pend_addr[7:0] ^ pend_addr[15:8];
                    pending    = 1'b0;
                end else begin
                    delay_left = delay_left - 2'd1;
                end
            end
            take_bits(2, bits);
            mem_ready <= (bits[1:0] != 2'b00);
        end
    end

    // ####################
    // checks and waits
    // ####################

    task automatic check_word(input int idx, input string name,
                              input z80_block_pkg::word_t got,
                              input z80_block_pkg::word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error: case %0d %s = %h, expected %h", idx, name, got, exp);
        end
    endtask

    task automatic check_flags(input int idx, input string name,
                               input z80_block_pkg::flags_t got,
                               input z80_block_pkg::flags_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error: case %0d %s = %h, expected %h", idx, name, got, exp);
        end
    endtask

    task automatic wait_ready(output bit ok);
        int cycles;
        cycles = 0;
        while (!cmd_ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        ok = cmd_ready;
        if (!ok) begin
            timeouts++;
            $display("Timeout: cmd_ready stayed low for %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic wait_done(output bit ok);
        ok = 1'b0;
        for (int cycles = 0; cycles < WAIT_LIMIT; cycles++) begin
            @(negedge clk);
            if (done) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            timeouts++;
            $display("Timeout: no done within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic run_case(input int idx, output bit ok);
        int base;
        base = idx * CASE_WORDS;
        wait_ready(ok);
        if (ok) begin
            @(posedge clk);
            cmd_valid  <= 1'b1;
            cmd_dir    <= case_mem[base][0];
            cmd_repeat <= case_mem[base + 1][0];
            cmd_a      <= case_mem[base + 2][7:0];
            cmd_bc     <= case_mem[base + 3];
            cmd_hl     <= case_mem[base + 4];
            cmd_f      <= case_mem[base + 5][7:0];
            @(posedge clk);
            cmd_valid <= 1'b0;
            wait_done(ok);
            if (ok) begin
                check_word(idx, "res_bc", res_bc, case_mem[base + 6]);
                check_word(idx, "res_hl", res_hl, case_mem[base + 7]);
                check_flags(idx, "res_f", res_f, case_mem[base + 8][7:0]);
            end
        end
    endtask

    initial begin
        bit ok;
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd_dir    = 1'b0;
        cmd_repeat = 1'b0;
        cmd_a      = '0;
        cmd_bc     = '0;
        cmd_hl     = '0;
        cmd_f      = '0;
        $readmemh("testbench/block_compare_cases.txt", case_mem);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        // a case starts as soon as the previous done is seen, so leftover bytes get flushed.
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i, ok);
            if (!ok) begin
                break;
            end
        end
        assert_failures = block_compare_top_inst.block_compare_assertions_inst.failures;
        $display("Summary: %0d value errors, %0d timeouts, %0d memory errors, %0d assertion errors",
                 value_errors, timeouts, protocol_errors, assert_failures);
        if (value_errors == 0 && timeouts == 0 && protocol_errors == 0 && assert_failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- testbench/block_compare_cases.txt
// columns: dir repeat a bc hl f, then expected bc hl f; all hex
// memory byte at address x is x[7:0] ^ x[15:8]
// cpi mismatch, C and bits 5 and 3 kept
0 0 55 0005 1000 29 0004 1001 2f
// cpd with a nibble borrow, bc reaches zero
1 0 20 0001 2034 00 0000 2033 12
// cpir match on the third byte, unread bytes flushed
0 1 32 000a 3000 01 0007 3003 47
// cpdr over six bytes with no match
1 1 00 0006 4010 28 0000 400a ba
// cpir with bc of 1, next command follows at once
0 1 50 0001 5000 80 0000 5001 42
// cpi a=10 against 01 sets H
0 0 10 0003 0001 00 0002 0002 16
// cpd equal byte, bc wraps from 0000
1 0 a5 0000 00a5 ff ffff 00a4 6f
// cpir across the top of memory, match on the fifth byte
0 1 02 0010 fffe 00 000b 0003 46
// cpir with no match until bc is zero
0 1 80 0005 0110 01 0000 0115 13

//--- list.f
source/z80_block_pkg.sv
source/block_fetch_unit.sv
source/operand_fifo.sv
source/cp_step_decoder.sv
source/compare_execute_unit.sv
source/block_compare_top.sv
testbench/tb_clock_gen.sv
testbench/block_compare_assertions.sv
testbench/tb_block_compare.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_block_compare
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
